// File: Makefile
TOP = hdmi_tx_config_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module $(TOP) -f sim.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q -x -F '** PASS **'

clean:
	rm -rf obj_dir

// File: sim.f
source/hdmi_tx_pkg.sv
source/hdmi_tx_command_table.sv
source/hdmi_tx_bus_port.sv
source/hdmi_tx_sequencer.sv
source/hdmi_tx_config.sv
tests/hdmi_tx_config_sva.sv
tests/hdmi_tx_config_tb.sv

// File: source/hdmi_tx_bus_port.sv
`timescale 1ns/1ps

module hdmi_tx_bus_port (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   issue,
    input  hdmi_tx_pkg::bus_cmd_t  cmd,
    input  logic                   bus_done,
    input  logic                   bus_ack_error,
    input  hdmi_tx_pkg::reg_data_t bus_rdata,
    output logic                   bus_valid,
    output hdmi_tx_pkg::bus_cmd_t  bus_cmd,
    output logic                   complete,
    output hdmi_tx_pkg::reg_data_t rdata
);

    // set for one cycle between a failed transfer and its repeat
    logic retry;

    // request handshake and retry control
    always_ff @(posedge clk) begin
        if (!reset) begin
            bus_valid <= 1'b0;
            complete  <= 1'b0;
            retry     <= 1'b0;
        end else begin
            complete <= 1'b0;
            retry    <= 1'b0;
            if (issue) begin
                bus_valid <= 1'b1;
            end else if (retry) begin
                // same command again, bus_cmd was left untouched
                bus_valid <= 1'b1;
            end else if (bus_valid && bus_done) begin
                bus_valid <= 1'b0;
                if (bus_ack_error) begin
                    retry <= 1'b1;
                end else begin
                    complete <= 1'b1;
                end
            end
        end
    end

    // command register, loaded only when a new command is issued
    always_ff @(posedge clk) begin
        if (issue) begin
            bus_cmd <= cmd;
        end
    end

    // read data of the last successful transfer
    always_ff @(posedge clk) begin
        if (bus_valid && bus_done && !bus_ack_error) begin
            rdata <= bus_rdata;
        end
    end

endmodule

// File: source/hdmi_tx_command_table.sv
`timescale 1ns/1ps

module hdmi_tx_command_table #(
    parameter bit output_422 = 1'b0
) (
    input  hdmi_tx_pkg::phase_t     phase,
    input  hdmi_tx_pkg::step_t      step,
    input  hdmi_tx_pkg::video_cfg_t video_cfg,
    output hdmi_tx_pkg::bus_cmd_t   cmd,
    output logic                    last
);

    // status checks are a single read
    localparam hdmi_tx_pkg::step_t check_len = 5'd1;

    function automatic hdmi_tx_pkg::bus_cmd_t write_reg(
        input hdmi_tx_pkg::reg_addr_t addr,
        input hdmi_tx_pkg::reg_data_t value
    );
        hdmi_tx_pkg::bus_cmd_t c;
        c.is_read = 1'b0;
        c.addr    = addr;
        c.value   = value;
        return c;
    endfunction

    function automatic hdmi_tx_pkg::bus_cmd_t read_reg(
        input hdmi_tx_pkg::reg_addr_t addr
    );
        hdmi_tx_pkg::bus_cmd_t c;
        c.is_read = 1'b1;
        c.addr    = addr;
        c.value   = '0;
        return c;
    endfunction

    always_comb begin
        cmd  = '0;
        last = 1'b0;
        case (phase)
            hdmi_tx_pkg::hpd_check: begin
                cmd  = read_reg(hdmi_tx_pkg::reg_hpd_state);
                last = (step == check_len);
            end
            hdmi_tx_pkg::power_up: begin
                last = (step == hdmi_tx_pkg::power_up_len);
                case (step)
                    // all circuits powered up, sync adjust off
                    5'd0:  cmd = write_reg(8'h41, 8'h10);
                    // fixed registers from the chip programming guide
                    5'd1:  cmd = write_reg(8'h98, 8'h03);
                    5'd2:  cmd = write_reg(8'h9A, 8'hE0);
                    5'd3:  cmd = write_reg(8'h9C, 8'h30);
                    5'd4:  cmd = write_reg(8'h9D, 8'h01);
                    5'd5:  cmd = write_reg(8'hA2, 8'hA4);
                    5'd6:  cmd = write_reg(8'hA3, 8'hA4);
                    5'd7:  cmd = write_reg(8'hE0, 8'hD0);
                    5'd8:  cmd = write_reg(8'hF9, 8'h00);
                    // enable HPD and monitor sense interrupts
                    5'd9:  cmd = write_reg(8'h94, 8'hC0);
                    // clear pending interrupt flags
                    5'd10: cmd = write_reg(8'h96, 8'hC0);
                    default: cmd = '0;
                endcase
            end
            hdmi_tx_pkg::init: begin
                last = (step == hdmi_tx_pkg::init_len);
                case (step)
                    // 44.1 kHz I2S, 24 bit RGB 4:4:4 input
                    5'd0:  cmd = write_reg(8'h15, 8'h00);
                    5'd1:  cmd = write_reg(8'h17, video_cfg.sync_cfg);
                    // 8 bit colour depth, 4:2:2 YCbCr output when selected
                    5'd2:  cmd = write_reg(8'h16, output_422 ? 8'hB1 : 8'h30);
                    // RGB in AVI InfoFrame
                    5'd3:  cmd = write_reg(8'h55, 8'h00);
                    // colour space converter off
                    5'd4:  cmd = write_reg(8'h18, 8'h46);
                    // HDMI mode, HDCP off
                    5'd5:  cmd = write_reg(8'hAF, 8'h06);
                    // no clock delay
                    5'd6:  cmd = write_reg(8'hBA, 8'h60);
                    // automatic CTS, I2S audio, 128xfs
                    5'd7:  cmd = write_reg(8'h0A, 8'h00);
                    // audio N value 0x01880 over three registers
                    5'd8:  cmd = write_reg(8'h01, 8'h00);
                    5'd9:  cmd = write_reg(8'h02, 8'h18);
                    5'd10: cmd = write_reg(8'h03, 8'h80);
                    // SPDIF off, internal MCLK
                    5'd11: cmd = write_reg(8'h0B, 8'h0E);
                    // I2S0 enabled, right justified
                    5'd12: cmd = write_reg(8'h0C, 8'h05);
                    // 16 bit I2S samples
                    5'd13: cmd = write_reg(8'h0D, 8'h10);
                    5'd14: cmd = write_reg(8'h3B, video_cfg.pixel_repeat_cfg);
                    5'd15: cmd = write_reg(8'h3C, video_cfg.vic_cfg);
                    default: cmd = '0;
                endcase
            end
            hdmi_tx_pkg::pll_check: begin
                cmd  = read_reg(hdmi_tx_pkg::reg_pll_status);
                last = (step == check_len);
            end
            hdmi_tx_pkg::power_down: begin
                last = (step == hdmi_tx_pkg::power_down_len);
                case (step)
                    // main power down
                    5'd0: cmd = write_reg(8'h41, 8'h50);
                    // keep HPD interrupts armed so a new monitor is seen
                    5'd1: cmd = write_reg(8'h94, 8'hC0);
                    5'd2: cmd = write_reg(8'h96, 8'hC0);
                    default: cmd = '0;
                endcase
            end
            default: begin
                // idle has nothing to send
                last = 1'b1;
            end
        endcase
    end

endmodule

// File: source/hdmi_tx_config.sv
`timescale 1ns/1ps

module hdmi_tx_config #(
    parameter bit output_422 = 1'b0
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     hdmi_int,
    input  hdmi_tx_pkg::video_cfg_t  video_cfg,
    input  logic                     bus_done,
    input  logic                     bus_ack_error,
    input  hdmi_tx_pkg::reg_data_t   bus_rdata,
    output logic                     bus_valid,
    output hdmi_tx_pkg::bus_cmd_t    bus_cmd,
    output logic                     ready
);

    hdmi_tx_pkg::phase_t    phase;
    hdmi_tx_pkg::step_t     step;
    hdmi_tx_pkg::bus_cmd_t  cmd;
    hdmi_tx_pkg::reg_data_t rdata;
    logic                   last;
    logic                   issue;
    logic                   complete;

    hdmi_tx_sequencer hdmi_tx_sequencer_i (
        .clk      (clk),
        .reset    (reset),
        .hdmi_int (hdmi_int),
        .complete (complete),
        .rdata    (rdata),
        .last     (last),
        .phase    (phase),
        .step     (step),
        .issue    (issue),
        .ready    (ready)
    );

    hdmi_tx_command_table #(
        .output_422 (output_422)
    ) hdmi_tx_command_table_i (
        .phase     (phase),
        .step      (step),
        .video_cfg (video_cfg),
        .cmd       (cmd),
        .last      (last)
    );

    hdmi_tx_bus_port hdmi_tx_bus_port_i (
        .clk           (clk),
        .reset         (reset),
        .issue         (issue),
        .cmd           (cmd),
        .bus_done      (bus_done),
        .bus_ack_error (bus_ack_error),
        .bus_rdata     (bus_rdata),
        .bus_valid     (bus_valid),
        .bus_cmd       (bus_cmd),
        .complete      (complete),
        .rdata         (rdata)
    );

endmodule

// File: source/hdmi_tx_pkg.sv
package hdmi_tx_pkg;

    // register bus widths
    typedef logic [7:0] reg_addr_t;
    typedef logic [7:0] reg_data_t;

    // index of a command inside one phase
    typedef logic [4:0] step_t;

    // configuration phases, walked in order by the sequencer
    typedef enum logic [2:0] {
        hpd_check  = 3'd0,
        power_up   = 3'd1,
        init       = 3'd2,
        pll_check  = 3'd3,
        power_down = 3'd4,
        idle       = 3'd5
    } phase_t;

    // one register bus transaction
    typedef struct packed {
        logic      is_read;
        reg_addr_t addr;
        // write value, ignored for reads
        reg_data_t value;
    } bus_cmd_t;

    // per-mode video settings loaded during init
    typedef struct packed {
        // value for register 0x17, sync polarity and aspect ratio
        reg_data_t sync_cfg;
        // value for register 0x3B, pixel repetition
        reg_data_t pixel_repeat_cfg;
        // value for register 0x3C, VIC
        reg_data_t vic_cfg;
    } video_cfg_t;

    // 7-bit bus address of the transmitter chip
    localparam logic [6:0] chip_addr = 7'h39;

    // status registers
    localparam reg_addr_t reg_hpd_state  = 8'h42;
    localparam reg_addr_t reg_pll_status = 8'h9E;

    // hot-plug detect state in 0x42
    localparam int hpd_bit = 6;
    // PLL lock flag in 0x9E
    localparam int pll_lock_bit = 4;

    // number of commands in each write phase
    localparam step_t power_up_len   = 5'd11;
    localparam step_t init_len       = 5'd16;
    localparam step_t power_down_len = 5'd3;

endpackage

// File: source/hdmi_tx_sequencer.sv
`timescale 1ns/1ps

module hdmi_tx_sequencer (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   hdmi_int,
    input  logic                   complete,
    input  hdmi_tx_pkg::reg_data_t rdata,
    input  logic                   last,
    output hdmi_tx_pkg::phase_t    phase,
    output hdmi_tx_pkg::step_t     step,
    output logic                   issue,
    output logic                   ready
);

    typedef enum logic [1:0] {
        issue_cmd = 2'd0,
        wait_cmd  = 2'd1,
        rest      = 2'd2
    } seq_state_t;

    seq_state_t state;

    // interrupt line sampling
    logic int_sync;
    logic int_prev;
    logic int_fall;
    logic int_pending;
    logic restart;

    assign int_fall = int_prev & ~int_sync;

    // a pending interrupt is only served once the sequence has settled
    assign restart = (state == rest) && int_pending;

    // one command per visit to issue_cmd, none once the phase is used up
    assign issue = (state == issue_cmd) && !last;

    // the chip pulls its interrupt line low, so only falling edges count
    always_ff @(posedge clk) begin
        if (!reset) begin
            int_sync    <= 1'b1;
            int_prev    <= 1'b1;
            int_pending <= 1'b0;
        end else begin
            int_sync <= hdmi_int;
            int_prev <= int_sync;
            if (int_fall) begin
                int_pending <= 1'b1;
            end else if (restart) begin
                int_pending <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            state <= issue_cmd;
            phase <= hdmi_tx_pkg::hpd_check;
            step  <= '0;
            ready <= 1'b0;
        end else begin
            case (state)
                issue_cmd: begin
                    if (!last) begin
                        state <= wait_cmd;
                    end else begin
                        // phase finished, pick the next one
                        step <= '0;
                        case (phase)
                            hdmi_tx_pkg::hpd_check: begin
                                if (rdata[hdmi_tx_pkg::hpd_bit]) begin
                                    phase <= hdmi_tx_pkg::power_up;
                                end else begin
                                    phase <= hdmi_tx_pkg::power_down;
                                end
                            end
                            hdmi_tx_pkg::power_up: begin
                                phase <= hdmi_tx_pkg::init;
                            end
                            hdmi_tx_pkg::init: begin
                                phase <= hdmi_tx_pkg::pll_check;
                            end
                            hdmi_tx_pkg::pll_check: begin
                                if (rdata[hdmi_tx_pkg::pll_lock_bit]) begin
                                    phase <= hdmi_tx_pkg::idle;
                                    state <= rest;
                                    ready <= 1'b1;
                                end else begin
                                    // PLL not locked yet, start over
                                    phase <= hdmi_tx_pkg::hpd_check;
                                end
                            end
                            hdmi_tx_pkg::power_down: begin
                                // no monitor attached
                                phase <= hdmi_tx_pkg::idle;
                                state <= rest;
                                ready <= 1'b0;
                            end
                            default: begin
                                state <= rest;
                            end
                        endcase
                    end
                end
                wait_cmd: begin
                    // bus port only reports error-free transfers
                    if (complete) begin
                        step  <= step + hdmi_tx_pkg::step_t'(1);
                        state <= issue_cmd;
                    end
                end
                rest: begin
                    if (restart) begin
                        ready <= 1'b0;
                        phase <= hdmi_tx_pkg::hpd_check;
                        step  <= '0;
                        state <= issue_cmd;
                    end
                end
                default: begin
                    state <= issue_cmd;
                end
            endcase
        end
    end

endmodule

// File: tests/hdmi_tx_config_sva.sv
`timescale 1ns/1ps

module hdmi_tx_config_sva (
    input logic                  clk,
    input logic                  reset,
    input logic                  bus_valid,
    input logic                  bus_done,
    input logic                  ready,
    input hdmi_tx_pkg::bus_cmd_t bus_cmd
);

    // the master reads the command over several cycles
    cmd_stable: assert property (@(posedge clk) disable iff (!reset)
        bus_valid |=> $stable(bus_cmd))
        else $error("bus_cmd changed while bus_valid was high");

    // request ends right after the master finishes
    valid_drops: assert property (@(posedge clk) disable iff (!reset)
        bus_valid && bus_done |=> !bus_valid)
        else $error("bus_valid still high in the cycle after bus_done");

    // outputs quiet in the cycle after reset
    reset_quiet: assert property (@(posedge clk)
        !reset |=> !ready && !bus_valid)
        else $error("ready or bus_valid high in the cycle after reset");

endmodule

bind hdmi_tx_config hdmi_tx_config_sva hdmi_tx_config_sva_i (
    .clk       (clk),
    .reset     (reset),
    .bus_valid (bus_valid),
    .bus_done  (bus_done),
    .ready     (ready),
    .bus_cmd   (bus_cmd)
);

// File: tests/hdmi_tx_config_tb.sv
`timescale 1ns/1ps

module hdmi_tx_config_tb;

    localparam bit out_422 = 1'b1;

    logic                    clk;
    logic                    reset;
    logic                    hdmi_int;
    hdmi_tx_pkg::video_cfg_t video_cfg;
    logic                    bus_done;
    logic                    bus_ack_error;
    hdmi_tx_pkg::reg_data_t  bus_rdata;
    logic                    bus_valid;
    hdmi_tx_pkg::bus_cmd_t   bus_cmd;
    logic                    ready;

    // slave model controls, set by the test while the DUT is quiet
    hdmi_tx_pkg::reg_data_t  hpd_reg;
    int                      pll_unlock_reads;
    logic                    inject_err;
    hdmi_tx_pkg::reg_addr_t  inject_addr;
    logic                    hold_ready_low;

    hdmi_tx_pkg::bus_cmd_t   expected_q [$];
    logic [31:0]             lfsr;
    int                      errors;
    string                   test_name;

    // register tables as {addr, value}
    logic [15:0] power_up_tab [$] = '{16'h4110, 16'h9803, 16'h9AE0, 16'h9C30, 16'h9D01,
                                      16'hA2A4, 16'hA3A4, 16'hE0D0, 16'hF900, 16'h94C0,
                                      16'h96C0};
    // 0x17, 0x16, 0x3B and 0x3C get their values in expected_cmd
    logic [15:0] init_tab [$] = '{16'h1500, 16'h1700, 16'h1600, 16'h5500, 16'h1846,
                                  16'hAF06, 16'hBA60, 16'h0A00, 16'h0100, 16'h0218,
                                  16'h0380, 16'h0B0E, 16'h0C05, 16'h0D10, 16'h3B00,
                                  16'h3C00};
    logic [15:0] power_down_tab [$] = '{16'h4150, 16'h94C0, 16'h96C0};

    hdmi_tx_config #(
        .output_422 (out_422)
    ) hdmi_tx_config_i (
        .clk           (clk),
        .reset         (reset),
        .hdmi_int      (hdmi_int),
        .video_cfg     (video_cfg),
        .bus_done      (bus_done),
        .bus_ack_error (bus_ack_error),
        .bus_rdata     (bus_rdata),
        .bus_valid     (bus_valid),
        .bus_cmd       (bus_cmd),
        .ready         (ready)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic hdmi_tx_pkg::bus_cmd_t expected_cmd(
        input hdmi_tx_pkg::phase_t     phase,
        input int                      step,
        input hdmi_tx_pkg::video_cfg_t cfg
    );
        hdmi_tx_pkg::bus_cmd_t c;
        logic [15:0]           entry;
        c = '0;
        entry = 16'h0000;
        case (phase)
            hdmi_tx_pkg::hpd_check: begin
                c.is_read = 1'b1;
                c.addr    = hdmi_tx_pkg::reg_hpd_state;
            end
            hdmi_tx_pkg::pll_check: begin
                c.is_read = 1'b1;
                c.addr    = hdmi_tx_pkg::reg_pll_status;
            end
            hdmi_tx_pkg::power_up:   entry = power_up_tab[step];
            hdmi_tx_pkg::init:       entry = init_tab[step];
            hdmi_tx_pkg::power_down: entry = power_down_tab[step];
            default:                 entry = 16'h0000;
        endcase
        if (!c.is_read) begin
            c.addr  = entry[15:8];
            c.value = entry[7:0];
            case (c.addr)
                8'h17:   c.value = cfg.sync_cfg;
                8'h3B:   c.value = cfg.pixel_repeat_cfg;
                8'h3C:   c.value = cfg.vic_cfg;
                8'h16:   c.value = out_422 ? 8'hB1 : 8'h30;
                default: c.value = entry[7:0];
            endcase
        end
        return c;
    endfunction

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output int v);
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = (v << 1) | int'(lfsr[0]);
        end
    endtask

    task automatic check_cmd(input string name, input hdmi_tx_pkg::bus_cmd_t exp,
                             input hdmi_tx_pkg::bus_cmd_t act);
        if (act !== exp) begin
            errors++;
            $display("Error %s: expected rd=%b addr=%h val=%h, actual rd=%b addr=%h val=%h",
                     name, exp.is_read, exp.addr, exp.value, act.is_read, act.addr, act.value);
        end
    endtask

    task automatic check_ready(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("Error %s: expected ready=%b, actual ready=%b", name, exp, act);
        end
    endtask

    task automatic finish_run();
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    endtask

    task automatic expect_phase(input hdmi_tx_pkg::phase_t phase, input int count);
        for (int i = 0; i < count; i++) begin
            expected_q.push_back(expected_cmd(phase, i, video_cfg));
        end
    endtask

    task automatic expect_bring_up();
        expect_phase(hdmi_tx_pkg::hpd_check, 1);
        expect_phase(hdmi_tx_pkg::power_up, power_up_tab.size());
        expect_phase(hdmi_tx_pkg::init, init_tab.size());
        expect_phase(hdmi_tx_pkg::pll_check, 1);
    endtask

    task automatic wait_queue_empty();
        int n;
        n = 0;
        while (expected_q.size() != 0 && n < 5000) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (expected_q.size() != 0) begin
            errors++;
            $display("%s: timed out with %0d expected requests missing",
                     test_name, expected_q.size());
            finish_run();
        end
    endtask

    task automatic wait_ready(input logic val);
        int n;
        n = 0;
        while (ready !== val && n < 50) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (ready !== val) begin
            $display("%s: timed out waiting for ready to become %b", test_name, val);
            check_ready(test_name, val, ready);
            finish_run();
        end
    endtask

    // chip interrupt is active low and the line returns high afterwards
    task automatic pulse_interrupt();
        hdmi_int = 1'b0;
        repeat (3) begin
            @(posedge clk);
            #1;
        end
        hdmi_int = 1'b1;
        repeat (3) begin
            @(posedge clk);
            #1;
        end
    endtask

    // bus master stand-in with random completion delay
    initial begin : bus_slave
        int r;
        int delay;
        forever begin
            @(posedge clk);
            #1;
            if (bus_valid) begin
                take_bits(3, r);
                delay = r % 6 + 1;
                for (int i = 1; i < delay; i++) begin
                    @(posedge clk);
                    #1;
                end
                bus_ack_error = 1'b0;
                bus_rdata     = 8'h00;
                if (bus_cmd.is_read && bus_cmd.addr == 8'h42) begin
                    bus_rdata = hpd_reg;
                end else if (bus_cmd.is_read && bus_cmd.addr == 8'h9E) begin
                    // unlocked reads keep every bit but the lock flag
                    bus_rdata = (pll_unlock_reads > 0) ? 8'hEF : 8'h10;
                    if (pll_unlock_reads > 0) begin
                        pll_unlock_reads--;
                    end
                end else if (inject_err && bus_cmd.addr == inject_addr) begin
                    bus_ack_error = 1'b1;
                    inject_err    = 1'b0;
                end
                bus_done = 1'b1;
                @(posedge clk);
                #1;
                bus_done      = 1'b0;
                bus_ack_error = 1'b0;
            end
        end
    end

    // requests and ready are sampled mid-cycle
    initial begin : compare_requests
        forever begin
            @(negedge clk);
            if (hold_ready_low) begin
                check_ready(test_name, 1'b0, ready);
            end
            if (bus_valid && bus_done) begin
                if (expected_q.size() == 0) begin
                    errors++;
                    $display("%s: unexpected request to register %h", test_name, bus_cmd.addr);
                end else begin
                    check_cmd(test_name, expected_q[0], bus_cmd);
                    // a failed transfer must come back with the same command
                    if (!bus_ack_error) begin
                        void'(expected_q.pop_front());
                    end
                end
            end
        end
    end

    initial begin : run_tests
        reset            = 1'b0;
        hdmi_int         = 1'b1;
        video_cfg        = {8'h02, 8'h40, 8'h10};
        bus_done         = 1'b0;
        bus_ack_error    = 1'b0;
        bus_rdata        = 8'h00;
        hpd_reg          = 8'h40;
        pll_unlock_reads = 0;
        inject_err       = 1'b0;
        inject_addr      = 8'h00;
        hold_ready_low   = 1'b0;
        lfsr             = 32'h3f4c_2e92;
        errors           = 0;
        test_name        = "bring_up";
        expect_bring_up();
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b1;
        wait_queue_empty();
        wait_ready(1'b1);

        test_name = "int_restart";
        expect_bring_up();
        pulse_interrupt();
        wait_ready(1'b0);
        wait_queue_empty();
        wait_ready(1'b1);

        test_name   = "ack_error";
        inject_err  = 1'b1;
        inject_addr = 8'h9D;
        expect_bring_up();
        pulse_interrupt();
        wait_queue_empty();
        wait_ready(1'b1);
        if (inject_err) begin
            errors++;
            $display("ack_error: the failing write to register 9D was never sent");
        end

        // second edge arrives while the sequence is running
        test_name = "int_during_bring_up";
        expect_bring_up();
        pulse_interrupt();
        wait_ready(1'b0);
        pulse_interrupt();
        wait_queue_empty();
        wait_ready(1'b1);
        // the held edge starts one more pass once ready is up
        expect_bring_up();
        wait_ready(1'b0);
        wait_queue_empty();
        wait_ready(1'b1);

        test_name        = "pll_unlocked";
        pll_unlock_reads = 1;
        expect_bring_up();
        expect_bring_up();
        pulse_interrupt();
        wait_ready(1'b0);
        hold_ready_low = 1'b1;
        wait_queue_empty();
        hold_ready_low = 1'b0;
        wait_ready(1'b1);

        test_name = "no_monitor";
        hpd_reg   = 8'h00;
        expect_phase(hdmi_tx_pkg::hpd_check, 1);
        expect_phase(hdmi_tx_pkg::power_down, power_down_tab.size());
        pulse_interrupt();
        wait_ready(1'b0);
        hold_ready_low = 1'b1;
        wait_queue_empty();
        repeat (40) @(posedge clk);
        #1;
        hold_ready_low = 1'b0;
        check_ready(test_name, 1'b0, ready);

        finish_run();
    end

endmodule
